// File: project.f
+incdir+.
pcie_rd_pkg.sv
rd_desc_fifo.sv
rd_scratchpad.sv
rd_slot_ctrl.sv
rd_stream_out.sv
pcie_cont_read.sv
tb_pcie_cont_read_asserts.sv
tb_pcie_cont_read.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f project.f --top-module tb_pcie_cont_read -o sim \
  && ./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_pcie_cont_read.sv
`include "pcie_rd_macros.svh"

module tb_pcie_cont_read;
  import pcie_rd_pkg::*;

  localparam int TIMEOUT = 2000;

  typedef struct {
    logic        is_host;
    logic [63:0] addr;
    logic [4:0]  len;
    logic [7:0]  htag;
    logic [1:0]  cid;
    logic [1:0]  ctag;
    logic [15:0] caddr;
    logic        complete;
  } row_t;

  logic pcie_clk;
  logic pcie_rst;
  pcie_addr_t host_desc_pcie_addr;
  logic [31:0] host_desc_ram_addr;
  beat_len_t host_desc_len;
  host_tag_t host_desc_tag;
  logic host_desc_valid;
  logic host_desc_ready;
  host_tag_t host_status_tag;
  logic host_status_valid;
  ctrl_word_t cores_ctrl_tdata;
  core_id_t cores_ctrl_tuser;
  logic cores_ctrl_tvalid;
  logic cores_ctrl_tready;
  beat_t cores_rx_tdata;
  dest_t cores_rx_tdest;
  logic cores_rx_tlast;
  logic cores_rx_tvalid;
  logic cores_rx_tready;
  pcie_addr_t pcie_dma_desc_pcie_addr;
  ram_addr_t pcie_dma_desc_ram_addr;
  beat_len_t pcie_dma_desc_len;
  slot_t pcie_dma_desc_tag;
  logic pcie_dma_desc_valid;
  logic pcie_dma_desc_ready;
  slot_t pcie_dma_status_tag;
  logic pcie_dma_status_valid;
  ram_addr_t pcie_ram_wr_addr;
  beat_t pcie_ram_wr_data;
  logic pcie_ram_wr_valid;

  row_t rows [13];
  int pend_idx [`SLOT_COUNT];
  logic [`SLOT_COUNT-1:0] free_model;
  int error_count;
  logic bp_en;
  int slot_h;
  int slot_c;

  // Observed transfers
  logic [63:0] desc_addr_q[$];
  logic [63:0] desc_ram_q[$];
  logic [63:0] desc_len_q[$];
  logic [63:0] desc_tag_q[$];
  logic [63:0] rx_data_q[$];
  logic [63:0] rx_dest_q[$];
  logic [63:0] rx_last_q[$];
  logic [63:0] status_q[$];

  pcie_cont_read i_pcie_cont_read (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
  end

  always @(posedge pcie_clk) begin
    if (!pcie_rst) begin
      if (pcie_dma_desc_valid && pcie_dma_desc_ready) begin
        desc_addr_q.push_back(64'(pcie_dma_desc_pcie_addr));
        desc_ram_q.push_back(64'(pcie_dma_desc_ram_addr));
        desc_len_q.push_back(64'(pcie_dma_desc_len));
        desc_tag_q.push_back(64'(pcie_dma_desc_tag));
      end
      if (cores_rx_tvalid && cores_rx_tready) begin
        rx_data_q.push_back(64'(cores_rx_tdata));
        rx_dest_q.push_back(64'(cores_rx_tdest));
        rx_last_q.push_back(64'(cores_rx_tlast));
      end
      if (host_status_valid) begin
        status_q.push_back(64'(host_status_tag));
      end
    end
  end

  // Random back-pressure on the stream and on the DMA descriptor port
  initial begin
    forever begin
      @(negedge pcie_clk);
      cores_rx_tready     = bp_en ? (($urandom % 4) != 0) : 1'b1;
      pcie_dma_desc_ready = bp_en ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Errors: %0d", error_count + 1);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic add_row(input int i, input logic h, input logic [63:0] a, input logic [4:0] l,
                         input logic [7:0] t, input logic [1:0] c, input logic [1:0] ct,
                         input logic [15:0] ca, input logic comp);
    rows[i] = '{h, a, l, t, c, ct, ca, comp};
  endtask

  function automatic int lowest_free(input logic [`SLOT_COUNT-1:0] mask);
    int s;
    s = -1;
    for (int i = `SLOT_COUNT - 1; i >= 0; i--) begin
      if (mask[i]) s = i;
    end
    return s;
  endfunction

  task automatic set_req(input int idx);
    row_t r;
    r = rows[idx];
    if (r.is_host) begin
      host_desc_pcie_addr = r.addr;
      host_desc_ram_addr  = {14'd0, r.cid, r.caddr};
      host_desc_len       = r.len;
      host_desc_tag       = r.htag;
      host_desc_valid     = 1'b1;
    end else begin
      cores_ctrl_tdata  = {r.addr, 16'd0, r.caddr, 14'd0, r.ctag, 11'd0, r.len};
      cores_ctrl_tuser  = r.cid;
      cores_ctrl_tvalid = 1'b1;
    end
  endtask

  // Waits for acceptance and returns the slot the request should take
  task automatic wait_accept(input int idx, output int slot);
    int n;
    n = 0;
    forever begin
      @(posedge pcie_clk);
      if (rows[idx].is_host ? host_desc_ready : cores_ctrl_tready) break;
      n++;
      if (n > TIMEOUT) abort_run("request was never accepted");
    end
    slot = lowest_free(free_model);
    free_model[slot] = 1'b0;
    pend_idx[slot] = idx;
    @(negedge pcie_clk);
    if (rows[idx].is_host) host_desc_valid = 1'b0;
    else cores_ctrl_tvalid = 1'b0;
  endtask

  task automatic check_desc(input int slot);
    row_t r;
    int n;
    r = rows[pend_idx[slot]];
    n = 0;
    while (desc_addr_q.size() == 0) begin
      @(posedge pcie_clk);
      n++;
      if (n > TIMEOUT) abort_run("no DMA descriptor was issued");
    end
    check("pcie_dma_desc_pcie_addr", desc_addr_q.pop_front(), r.addr);
    check("pcie_dma_desc_ram_addr", desc_ram_q.pop_front(), 64'({slot[2:0], 4'd0}));
    check("pcie_dma_desc_len", desc_len_q.pop_front(), 64'(r.len));
    check("pcie_dma_desc_tag", desc_tag_q.pop_front(), 64'(slot));
  endtask

  // DMA model: fill the slot, then report completion
  task automatic finish_slot(input int slot);
    row_t r;
    int n;
    logic [63:0] dest;
    r = rows[pend_idx[slot]];
    dest = r.is_host ? 64'({r.cid, 2'b00}) : 64'({r.cid, r.ctag});
    for (int i = 0; i < r.len; i++) begin
      @(negedge pcie_clk);
      pcie_ram_wr_addr  = ram_addr_t'({slot[2:0], 4'd0} + i);
      pcie_ram_wr_data  = r.addr + 64'(i);
      pcie_ram_wr_valid = 1'b1;
    end
    @(negedge pcie_clk);
    pcie_ram_wr_valid     = 1'b0;
    pcie_dma_status_tag   = slot_t'(slot);
    pcie_dma_status_valid = 1'b1;
    @(negedge pcie_clk);
    pcie_dma_status_valid = 1'b0;
    n = 0;
    while (rx_data_q.size() < int'(r.len) + 1) begin
      @(posedge pcie_clk);
      n++;
      if (n > TIMEOUT) abort_run("stream to the cores did not complete");
    end
    check("cores_rx_tdata", rx_data_q.pop_front(), {16'd0, r.caddr, 32'd0});
    check("cores_rx_tdest", rx_dest_q.pop_front(), dest);
    check("cores_rx_tlast", rx_last_q.pop_front(), 64'(r.len == 0));
    for (int i = 0; i < r.len; i++) begin
      check("cores_rx_tdata", rx_data_q.pop_front(), r.addr + 64'(i));
      check("cores_rx_tdest", rx_dest_q.pop_front(), dest);
      check("cores_rx_tlast", rx_last_q.pop_front(), 64'(i == r.len - 1));
    end
    if (r.is_host) begin
      n = 0;
      while (status_q.size() == 0) begin
        @(posedge pcie_clk);
        n++;
        if (n > TIMEOUT) abort_run("host status never returned");
      end
      check("host_status_tag", status_q.pop_front(), 64'(r.htag));
    end else begin
      repeat (3) @(posedge pcie_clk);
      check("host_status_valid count", 64'(status_q.size()), 64'd0);
    end
    free_model[slot] = 1'b1;
  endtask

  task automatic issue(input int idx);
    int slot;
    @(negedge pcie_clk);
    set_req(idx);
    wait_accept(idx, slot);
    check_desc(slot);
    if (rows[idx].complete) finish_slot(slot);
  endtask

  initial begin
    void'($urandom(32'hfc7f34e5));
    error_count = 0;
    bp_en = 1'b0;
    free_model = '1;
    pcie_rst = 1'b1;
    host_desc_pcie_addr = '0;
    host_desc_ram_addr = '0;
    host_desc_len = '0;
    host_desc_tag = '0;
    host_desc_valid = 1'b0;
    cores_ctrl_tdata = '0;
    cores_ctrl_tuser = '0;
    cores_ctrl_tvalid = 1'b0;
    cores_rx_tready = 1'b1;
    pcie_dma_desc_ready = 1'b1;
    pcie_dma_status_tag = '0;
    pcie_dma_status_valid = 1'b0;
    pcie_ram_wr_addr = '0;
    pcie_ram_wr_data = '0;
    pcie_ram_wr_valid = 1'b0;

    // src, PCIe address, length, host tag, core id, core tag, core address, complete
    add_row(0, 1, 64'h1000_0000_0000_0100, 5'd4, 8'h11, 2'd1, 2'd0, 16'h0040, 1);
    add_row(1, 0, 64'h2000_0000_0000_0200, 5'd6, 8'h00, 2'd2, 2'd3, 16'h0100, 1);
    add_row(2, 1, 64'h3000_0000_0000_0000, 5'd1, 8'h21, 2'd0, 2'd0, 16'h1000, 0);
    add_row(3, 0, 64'h3100_0000_0000_0040, 5'd16, 8'h00, 2'd3, 2'd1, 16'h2000, 0);
    add_row(4, 1, 64'h3200_0000_0000_0080, 5'd3, 8'h22, 2'd2, 2'd0, 16'h3000, 0);
    add_row(5, 0, 64'h3300_0000_0000_00c0, 5'd5, 8'h00, 2'd1, 2'd2, 16'h4000, 0);
    add_row(6, 0, 64'h3400_0000_0000_0100, 5'd2, 8'h00, 2'd0, 2'd3, 16'h5000, 0);
    add_row(7, 1, 64'h3500_0000_0000_0140, 5'd8, 8'h23, 2'd3, 2'd0, 16'h6000, 0);
    add_row(8, 0, 64'h3600_0000_0000_0180, 5'd7, 8'h00, 2'd2, 2'd1, 16'h7000, 0);
    add_row(9, 1, 64'h3700_0000_0000_01c0, 5'd15, 8'hfe, 2'd1, 2'd0, 16'h8000, 0);
    add_row(10, 1, 64'h4000_0000_0000_0000, 5'd3, 8'h42, 2'd2, 2'd0, 16'h9000, 1);
    add_row(11, 1, 64'h5000_0000_0000_0000, 5'd2, 8'h51, 2'd3, 2'd0, 16'ha000, 1);
    add_row(12, 0, 64'h6000_0000_0000_0000, 5'd3, 8'h00, 2'd0, 2'd2, 16'hb000, 1);

    repeat (8) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_rst = 1'b0;
    #1;
    check("pcie_dma_desc_valid", 64'(pcie_dma_desc_valid), 64'd0);
    check("cores_rx_tvalid", 64'(cores_rx_tvalid), 64'd0);
    check("host_status_valid", 64'(host_status_valid), 64'd0);
    check("host_desc_ready", 64'(host_desc_ready), 64'd1);
    check("cores_ctrl_tready", 64'(cores_ctrl_tready), 64'd1);
    bp_en = 1'b1;

    for (int i = 0; i < 10; i++) begin
      issue(i);
    end

    // All eight slots busy
    @(negedge pcie_clk);
    #1;
    check("host_desc_ready", 64'(host_desc_ready), 64'd0);
    check("cores_ctrl_tready", 64'(cores_ctrl_tready), 64'd0);
    finish_slot(3);
    @(negedge pcie_clk);
    #1;
    check("host_desc_ready", 64'(host_desc_ready), 64'd1);
    issue(10);
    for (int s = 0; s < `SLOT_COUNT; s++) begin
      if (!free_model[s]) finish_slot(s);
    end

    // Host and core request in the same cycle
    @(negedge pcie_clk);
    set_req(11);
    set_req(12);
    #1;
    check("cores_ctrl_tready", 64'(cores_ctrl_tready), 64'd0);
    wait_accept(11, slot_h);
    wait_accept(12, slot_c);
    check_desc(slot_h);
    check_desc(slot_c);
    finish_slot(slot_h);
    finish_slot(slot_c);

    repeat (4) @(posedge pcie_clk);
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb_pcie_cont_read_asserts.sv
`include "pcie_rd_macros.svh"

module tb_pcie_cont_read_asserts (
  input logic                    pcie_clk,
  input logic                    pcie_rst,
  input pcie_rd_pkg::pcie_addr_t pcie_dma_desc_pcie_addr,
  input pcie_rd_pkg::ram_addr_t  pcie_dma_desc_ram_addr,
  input pcie_rd_pkg::beat_len_t  pcie_dma_desc_len,
  input pcie_rd_pkg::slot_t      pcie_dma_desc_tag,
  input logic                    pcie_dma_desc_valid,
  input logic                    pcie_dma_desc_ready,
  input pcie_rd_pkg::beat_t      cores_rx_tdata,
  input pcie_rd_pkg::dest_t      cores_rx_tdest,
  input logic                    cores_rx_tlast,
  input logic                    cores_rx_tvalid,
  input logic                    cores_rx_tready,
  input pcie_rd_pkg::host_tag_t  host_status_tag,
  input logic                    host_status_valid
);
  import pcie_rd_pkg::*;

  desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    pcie_dma_desc_valid && !pcie_dma_desc_ready |=> pcie_dma_desc_valid
      && $stable(pcie_dma_desc_pcie_addr) && $stable(pcie_dma_desc_ram_addr)
      && $stable(pcie_dma_desc_len) && $stable(pcie_dma_desc_tag))
    else $error("DMA descriptor changed while stalled");

  beat_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    cores_rx_tvalid && !cores_rx_tready |=> cores_rx_tvalid
      && $stable(cores_rx_tdata) && $stable(cores_rx_tdest) && $stable(cores_rx_tlast))
    else $error("Stream beat changed while stalled");

  // Zero tag marks a core request
  status_tag: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    host_status_valid |-> host_status_tag != '0)
    else $error("Host status with zero tag");

endmodule

bind pcie_cont_read tb_pcie_cont_read_asserts i_asserts (.*);

// File: pcie_cont_read.sv
`include "pcie_rd_macros.svh"

module pcie_cont_read (
  input  logic                         pcie_clk,
  input  logic                         pcie_rst,
  input  pcie_rd_pkg::pcie_addr_t      host_desc_pcie_addr,
  input  logic [`HOST_RAM_ADDR_W-1:0]  host_desc_ram_addr,
  input  pcie_rd_pkg::beat_len_t       host_desc_len,
  input  pcie_rd_pkg::host_tag_t       host_desc_tag,
  input  logic                         host_desc_valid,
  output logic                         host_desc_ready,
  output pcie_rd_pkg::host_tag_t       host_status_tag,
  output logic                         host_status_valid,
  input  pcie_rd_pkg::ctrl_word_t      cores_ctrl_tdata,
  input  pcie_rd_pkg::core_id_t        cores_ctrl_tuser,
  input  logic                         cores_ctrl_tvalid,
  output logic                         cores_ctrl_tready,
  output pcie_rd_pkg::beat_t           cores_rx_tdata,
  output pcie_rd_pkg::dest_t           cores_rx_tdest,
  output logic                         cores_rx_tlast,
  output logic                         cores_rx_tvalid,
  input  logic                         cores_rx_tready,
  output pcie_rd_pkg::pcie_addr_t      pcie_dma_desc_pcie_addr,
  output pcie_rd_pkg::ram_addr_t       pcie_dma_desc_ram_addr,
  output pcie_rd_pkg::beat_len_t       pcie_dma_desc_len,
  output pcie_rd_pkg::slot_t           pcie_dma_desc_tag,
  output logic                         pcie_dma_desc_valid,
  input  logic                         pcie_dma_desc_ready,
  input  pcie_rd_pkg::slot_t           pcie_dma_status_tag,
  input  logic                         pcie_dma_status_valid,
  input  pcie_rd_pkg::ram_addr_t       pcie_ram_wr_addr,
  input  pcie_rd_pkg::beat_t           pcie_ram_wr_data,
  input  logic                         pcie_ram_wr_valid
);
  import pcie_rd_pkg::*;

  logic                desc_fifo_full;
  logic                desc_wr_valid;
  logic [`DESC_W-1:0]  desc_wr_data;
  logic                rdout_wr_valid;
  logic [`RDOUT_W-1:0] rdout_wr_data;
  logic                rdout_valid;
  logic [`RDOUT_W-1:0] rdout_data;
  logic                rdout_ready;
  ram_addr_t           sp_rd_addr;
  logic                sp_rd_en;
  beat_t               sp_rd_data;
  logic                done_valid;
  slot_t               done_slot;

  rd_slot_ctrl i_slot_ctrl (
    .pcie_clk              (pcie_clk),
    .pcie_rst              (pcie_rst),
    .host_desc_pcie_addr   (host_desc_pcie_addr),
    .host_desc_ram_addr    (host_desc_ram_addr),
    .host_desc_len         (host_desc_len),
    .host_desc_tag         (host_desc_tag),
    .host_desc_valid       (host_desc_valid),
    .host_desc_ready       (host_desc_ready),
    .cores_ctrl_tdata      (cores_ctrl_tdata),
    .cores_ctrl_tuser      (cores_ctrl_tuser),
    .cores_ctrl_tvalid     (cores_ctrl_tvalid),
    .cores_ctrl_tready     (cores_ctrl_tready),
    .desc_fifo_full        (desc_fifo_full),
    .pcie_dma_status_tag   (pcie_dma_status_tag),
    .pcie_dma_status_valid (pcie_dma_status_valid),
    .done_valid            (done_valid),
    .done_slot             (done_slot),
    .desc_wr_valid         (desc_wr_valid),
    .desc_wr_data          (desc_wr_data),
    .rdout_wr_valid        (rdout_wr_valid),
    .rdout_wr_data         (rdout_wr_data),
    .host_status_tag       (host_status_tag),
    .host_status_valid     (host_status_valid)
  );

  // Slot count bounds both FIFOs, so their input ready is not needed
  rd_desc_fifo #(
    .WIDTH   (`DESC_W),
    .DEPTH_W (`FIFO_DEPTH_W)
  ) i_desc_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din_valid  (desc_wr_valid),
    .din        (desc_wr_data),
    .din_ready  (),
    .dout_valid (pcie_dma_desc_valid),
    .dout       ({pcie_dma_desc_pcie_addr, pcie_dma_desc_ram_addr,
                  pcie_dma_desc_len, pcie_dma_desc_tag}),
    .dout_ready (pcie_dma_desc_ready),
    .full       (desc_fifo_full)
  );

  rd_desc_fifo #(
    .WIDTH   (`RDOUT_W),
    .DEPTH_W (`FIFO_DEPTH_W)
  ) i_rdout_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din_valid  (rdout_wr_valid),
    .din        (rdout_wr_data),
    .din_ready  (),
    .dout_valid (rdout_valid),
    .dout       (rdout_data),
    .dout_ready (rdout_ready),
    .full       ()
  );

  rd_scratchpad i_scratchpad (
    .pcie_clk (pcie_clk),
    .wr_addr  (pcie_ram_wr_addr),
    .wr_data  (pcie_ram_wr_data),
    .wr_valid (pcie_ram_wr_valid),
    .rd_addr  (sp_rd_addr),
    .rd_en    (sp_rd_en),
    .rd_data  (sp_rd_data)
  );

  rd_stream_out i_stream_out (
    .pcie_clk        (pcie_clk),
    .pcie_rst        (pcie_rst),
    .desc_valid      (rdout_valid),
    .desc_data       (rdout_data),
    .desc_ready      (rdout_ready),
    .rd_addr         (sp_rd_addr),
    .rd_en           (sp_rd_en),
    .rd_data         (sp_rd_data),
    .cores_rx_tdata  (cores_rx_tdata),
    .cores_rx_tdest  (cores_rx_tdest),
    .cores_rx_tlast  (cores_rx_tlast),
    .cores_rx_tvalid (cores_rx_tvalid),
    .cores_rx_tready (cores_rx_tready),
    .done_valid      (done_valid),
    .done_slot       (done_slot)
  );

endmodule

// File: rd_stream_out.sv
`include "pcie_rd_macros.svh"

module rd_stream_out (
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  logic                   desc_valid,
  input  logic [`RDOUT_W-1:0]    desc_data,
  output logic                   desc_ready,
  output pcie_rd_pkg::ram_addr_t rd_addr,
  output logic                   rd_en,
  input  pcie_rd_pkg::beat_t     rd_data,
  output pcie_rd_pkg::beat_t     cores_rx_tdata,
  output pcie_rd_pkg::dest_t     cores_rx_tdest,
  output logic                   cores_rx_tlast,
  output logic                   cores_rx_tvalid,
  input  logic                   cores_rx_tready,
  output logic                   done_valid,
  output pcie_rd_pkg::slot_t     done_slot
);
  import pcie_rd_pkg::*;

  stream_state_t state;
  slot_t         cur_slot;
  beat_len_t     cur_len;
  dest_t         cur_dest;
  core_addr_t    cur_caddr;
  beat_len_t     beat_cnt;
  logic          beat_xfer;
  logic          last_beat;

  assign desc_ready = (state == IDLE);
  assign rd_en      = (state == READ);
  assign rd_addr    = {cur_slot, beat_cnt[`SLOT_BEATS_W-1:0]};

  assign cores_rx_tvalid = (state == HEADER) || (state == DATA);
  assign cores_rx_tdest  = cur_dest;
  assign beat_xfer       = cores_rx_tvalid && cores_rx_tready;

  // Zero length readout ends on the header
  assign last_beat = (state == HEADER) ? (cur_len == '0) : (beat_cnt + 1'b1 == cur_len);
  assign cores_rx_tlast = last_beat;

  // Header has the core address in bits 47:32
  assign cores_rx_tdata = (state == DATA) ? rd_data :
                          {{(`BEAT_W - 32 - `CORE_ADDR_W){1'b0}}, cur_caddr, 32'd0};

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state      <= IDLE;
      done_valid <= 1'b0;
    end else begin
      done_valid <= beat_xfer && last_beat;
      case (state)
        IDLE: begin
          if (desc_valid) begin
            state <= HEADER;
          end
        end
        HEADER: begin
          if (beat_xfer) begin
            state <= last_beat ? IDLE : READ;
          end
        end
        READ: begin
          state <= DATA;
        end
        DATA: begin
          if (beat_xfer) begin
            state <= last_beat ? IDLE : READ;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (desc_valid && desc_ready) begin
      {cur_slot, cur_len, cur_dest, cur_caddr} <= desc_data;
      beat_cnt <= '0;
    end else if (state == DATA && beat_xfer) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
    if (beat_xfer && last_beat) begin
      done_slot <= cur_slot;
    end
  end

endmodule

// File: rd_slot_ctrl.sv
`include "pcie_rd_macros.svh"

module rd_slot_ctrl (
  input  logic                         pcie_clk,
  input  logic                         pcie_rst,
  input  pcie_rd_pkg::pcie_addr_t      host_desc_pcie_addr,
  input  logic [`HOST_RAM_ADDR_W-1:0]  host_desc_ram_addr,
  input  pcie_rd_pkg::beat_len_t       host_desc_len,
  input  pcie_rd_pkg::host_tag_t       host_desc_tag,
  input  logic                         host_desc_valid,
  output logic                         host_desc_ready,
  input  pcie_rd_pkg::ctrl_word_t      cores_ctrl_tdata,
  input  pcie_rd_pkg::core_id_t        cores_ctrl_tuser,
  input  logic                         cores_ctrl_tvalid,
  output logic                         cores_ctrl_tready,
  input  logic                         desc_fifo_full,
  input  pcie_rd_pkg::slot_t           pcie_dma_status_tag,
  input  logic                         pcie_dma_status_valid,
  input  logic                         done_valid,
  input  pcie_rd_pkg::slot_t           done_slot,
  output logic                         desc_wr_valid,
  output logic [`DESC_W-1:0]           desc_wr_data,
  output logic                         rdout_wr_valid,
  output logic [`RDOUT_W-1:0]          rdout_wr_data,
  output pcie_rd_pkg::host_tag_t       host_status_tag,
  output logic                         host_status_valid
);
  import pcie_rd_pkg::*;

  logic [`SLOT_COUNT-1:0] free_mask;
  slot_t                  alloc_slot;
  logic                   slot_avail;
  logic                   host_acc;
  logic                   core_acc;

  pcie_addr_t req_pcie_addr;
  beat_len_t  req_len;
  dest_t      req_dest;
  core_addr_t req_caddr;
  host_tag_t  req_htag;

  beat_len_t  len_tab   [`SLOT_COUNT];
  dest_t      dest_tab  [`SLOT_COUNT];
  core_addr_t caddr_tab [`SLOT_COUNT];
  host_tag_t  htag_tab  [`SLOT_COUNT];

  // Lowest free slot wins
  always_comb begin
    alloc_slot = '0;
    for (int i = `SLOT_COUNT - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        alloc_slot = slot_t'(i);
      end
    end
  end

  assign slot_avail        = |free_mask;
  assign host_desc_ready   = !desc_fifo_full && slot_avail;
  assign cores_ctrl_tready = host_desc_ready && !host_desc_valid;
  assign host_acc          = host_desc_valid && host_desc_ready;
  assign core_acc          = cores_ctrl_tvalid && cores_ctrl_tready;

  // Host fields, otherwise the core control word fields
  always_comb begin
    if (host_desc_valid) begin
      req_pcie_addr = host_desc_pcie_addr;
      req_len       = host_desc_len;
      req_dest      = {host_desc_ram_addr[`CORE_ADDR_W +: `CORE_ID_W],
                       {(`DEST_W - `CORE_ID_W){1'b0}}};
      req_caddr     = host_desc_ram_addr[`CORE_ADDR_W-1:0];
      req_htag      = host_desc_tag;
    end else begin
      req_pcie_addr = cores_ctrl_tdata[127:64];
      req_len       = cores_ctrl_tdata[`LEN_W-1:0];
      req_dest      = {cores_ctrl_tuser, cores_ctrl_tdata[17:16]};
      req_caddr     = cores_ctrl_tdata[32 +: `CORE_ADDR_W];
      req_htag      = '0;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      free_mask         <= '1;
      desc_wr_valid     <= 1'b0;
      rdout_wr_valid    <= 1'b0;
      host_status_valid <= 1'b0;
    end else begin
      // A slot being freed is never the one being allocated
      free_mask <= (free_mask
                    & ~(`SLOT_COUNT'(host_acc || core_acc) << alloc_slot))
                   | (`SLOT_COUNT'(done_valid) << done_slot);
      desc_wr_valid     <= host_acc || core_acc;
      rdout_wr_valid    <= pcie_dma_status_valid;
      host_status_valid <= done_valid && (htag_tab[done_slot] != '0);
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (host_acc || core_acc) begin
      len_tab[alloc_slot]   <= req_len;
      dest_tab[alloc_slot]  <= req_dest;
      caddr_tab[alloc_slot] <= req_caddr;
      htag_tab[alloc_slot]  <= req_htag;
      desc_wr_data <= {req_pcie_addr, alloc_slot, {`SLOT_BEATS_W{1'b0}}, req_len, alloc_slot};
    end
    if (pcie_dma_status_valid) begin
      rdout_wr_data <= {pcie_dma_status_tag, len_tab[pcie_dma_status_tag],
                        dest_tab[pcie_dma_status_tag], caddr_tab[pcie_dma_status_tag]};
    end
    host_status_tag <= htag_tab[done_slot];
  end

endmodule

// File: rd_scratchpad.sv
`include "pcie_rd_macros.svh"

module rd_scratchpad (
  input  logic                   pcie_clk,
  input  pcie_rd_pkg::ram_addr_t wr_addr,
  input  pcie_rd_pkg::beat_t     wr_data,
  input  logic                   wr_valid,
  input  pcie_rd_pkg::ram_addr_t rd_addr,
  input  logic                   rd_en,
  output pcie_rd_pkg::beat_t     rd_data
);
  import pcie_rd_pkg::*;

  localparam int WORDS = `SLOT_COUNT * (2 ** `SLOT_BEATS_W);

  // Slot index in the upper address bits, beat index below
  beat_t mem [WORDS];

  always_ff @(posedge pcie_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read word holds until the next read
  always_ff @(posedge pcie_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: rd_desc_fifo.sv
`include "pcie_rd_macros.svh"

module rd_desc_fifo #(
  parameter int WIDTH   = 8,
  parameter int DEPTH_W = `FIFO_DEPTH_W
) (
  input  logic             pcie_clk,
  input  logic             pcie_rst,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             din_ready,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready,
  output logic             full
);

  localparam int DEPTH = 2 ** DEPTH_W;

  logic [WIDTH-1:0]   mem [DEPTH];
  logic [DEPTH_W-1:0] wr_ptr;
  logic [DEPTH_W-1:0] rd_ptr;
  logic [DEPTH_W:0]   count;
  logic               push;
  logic               pop;

  assign full       = (count == (DEPTH_W + 1)'(DEPTH));
  assign din_ready  = !full;
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];
  assign push       = din_valid && din_ready;
  assign pop        = dout_valid && dout_ready;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (DEPTH_W + 1)'(push) - (DEPTH_W + 1)'(pop);
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

// File: pcie_rd_pkg.sv
`include "pcie_rd_macros.svh"

package pcie_rd_pkg;

  typedef logic [`SLOT_W-1:0]      slot_t;
  typedef logic [`RAM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [`LEN_W-1:0]       beat_len_t;
  typedef logic [`BEAT_W-1:0]      beat_t;
  typedef logic [`PCIE_ADDR_W-1:0] pcie_addr_t;
  typedef logic [`HOST_TAG_W-1:0]  host_tag_t;
  typedef logic [`CORE_ID_W-1:0]   core_id_t;
  typedef logic [`DEST_W-1:0]      dest_t;
  typedef logic [`CORE_ADDR_W-1:0] core_addr_t;
  typedef logic [`CTRL_W-1:0]      ctrl_word_t;

  // Readout engine states
  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    READ,
    DATA
  } stream_state_t;

endpackage

// File: pcie_rd_macros.svh
`ifndef PCIE_RD_MACROS_SVH
`define PCIE_RD_MACROS_SVH

`define SLOT_COUNT      8
`define SLOT_W          3
// 16 beats of 64 bits per slot
`define SLOT_BEATS_W    4
`define RAM_ADDR_W      (`SLOT_W + `SLOT_BEATS_W)
`define LEN_W           5
`define BEAT_W          64
`define PCIE_ADDR_W     64
`define HOST_TAG_W      8
`define HOST_RAM_ADDR_W 32
`define CORE_ID_W       2
// Core id followed by the 2-bit core tag
`define DEST_W          4
`define CORE_ADDR_W     16
`define CTRL_W          128
`define FIFO_DEPTH_W    `SLOT_W

// Packed FIFO entry widths
`define DESC_W  (`PCIE_ADDR_W + `RAM_ADDR_W + `LEN_W + `SLOT_W)
`define RDOUT_W (`SLOT_W + `LEN_W + `DEST_W + `CORE_ADDR_W)

`endif
